//--- sources.f
verilog/channelPkg.sv
verilog/pipelinePkg.sv
verilog/topReceiver.sv
verilog/botFifo.sv
verilog/rotationTimer.sv
verilog/pipelineControl.sv
verilog/permutationStage.sv
verilog/permutationPipeline.sv
testbench/topTransmitter.sv
testbench/testPermutationPipeline.sv

//--- testbench/testPermutationPipeline.sv
`default_nettype none

module testPermutationPipeline;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int rowCount = 24;
    localparam int holdRow = 11; // first row of the slowDown test

    logic                     clock;
    logic                     rst;
    channelPkg::topSymbol     topChannel;
    pipelinePkg::botWord      botIn;
    logic                     writeBotIn;
    logic                     almostFull;
    logic                     slowDown;
    logic                     resultValid;
    pipelinePkg::pcoeffResult result;
    logic                     send;
    logic                     done;
    pipelinePkg::botWord      topValue;

    pipelinePkg::botWord      botTable [rowCount];
    int                       holdTable [rowCount];
    pipelinePkg::pcoeffResult expectedQ [$];
    pipelinePkg::pcoeffResult expectedResult;
    pipelinePkg::botWord      topA;
    pipelinePkg::botWord      topB;
    logic                     checkSpacing;
    int                       seed;
    int                       errorCount;
    int                       startErrors;
    int                       resultCount;
    int                       savedCount;
    int                       testCount;
    int                       cycle;
    int                       lastValidCycle;
    int                       firstWriteCycle;
    int                       gap;
    int                       expectedGap;

    permutationPipeline dut0 (
        .clock       (clock),
        .rst         (rst),
        .topChannel  (topChannel),
        .botIn       (botIn),
        .writeBotIn  (writeBotIn),
        .almostFull  (almostFull),
        .slowDown    (slowDown),
        .resultValid (resultValid),
        .result      (result)
    );

    topTransmitter topTransmitter0 (
        .clock    (clock),
        .send     (send),
        .topValue (topValue),
        .channel  (topChannel),
        .done     (done)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // results checked in write order at the falling edge
    always @(negedge clock) begin
        if (rst && resultValid) begin
            if (expectedQ.size() == 0) begin
                $display("a result arrived at %0t with no bot outstanding", $time);
                errorCount++;
            end else begin
                expectedResult = expectedQ.pop_front();
                if (result !== expectedResult) begin
                    $display("ERR %0t result expected %h actual %h", $time,
                             expectedResult, result);
                    errorCount++;
                end
            end
            if (checkSpacing) begin
                gap = lastValidCycle == 0 ? cycle - firstWriteCycle : cycle - lastValidCycle;
                expectedGap = lastValidCycle == 0 ? 11 : 8; // write edge to first result is 11
                if (gap != expectedGap) begin
                    $display("ERR %0t resultValid interval expected %0d actual %0d", $time,
                             expectedGap, gap);
                    errorCount++;
                end
            end
            lastValidCycle = cycle;
            resultCount++;
        end
    end

    // sum of overlaps and subset count over the eight rotated tops
    function automatic pipelinePkg::pcoeffResult referenceResult(
        input pipelinePkg::botWord bot,
        input pipelinePkg::botWord top
    );
        pipelinePkg::pcoeffResult expected;
        pipelinePkg::botWord      permuted;
        int                       shift;
        expected = '0;
        for (int r = 0; r < pipelinePkg::rotationCount; r++) begin
            shift = pipelinePkg::rotationStep * r;
            permuted = (top << shift) | (top >> (pipelinePkg::botWidth - shift));
            for (int b = 0; b < pipelinePkg::botWidth; b++) begin
                expected.sum = expected.sum + 11'(bot[b] & permuted[b]);
            end
            if ((bot & ~permuted) == '0) begin
                expected.count = expected.count + 1'b1;
            end
        end
        return expected;
    endfunction

    task waitCycle();
        @(posedge clock);
        #5;
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0b actual %0b", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timed out waiting for %s", what);
        errorCount++;
    endtask

    task automatic writeRow(input int index, input pipelinePkg::botWord top);
        int waited;
        waited = 0;
        while (almostFull && waited < 100) begin
            waitCycle();
            waited++;
        end
        if (almostFull) begin
            reportTimeout("almostFull to fall");
        end
        botIn = botTable[index];
        writeBotIn = 1'b1;
        expectedQ.push_back(referenceResult(botTable[index], top));
        waitCycle();
        writeBotIn = 1'b0;
    endtask

    task automatic sendTop(input pipelinePkg::botWord top);
        int waited;
        waited = 0;
        topValue = top;
        send = 1'b1;
        waitCycle();
        send = 1'b0;
        while (!done && waited < 200) begin
            @(negedge clock); // done is a one cycle pulse
            waited++;
        end
        if (!done) begin
            reportTimeout("the top frame to finish");
        end
        waitCycle();
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        while (expectedQ.size() != 0 && waited < 300) begin
            waitCycle();
            waited++;
        end
        if (expectedQ.size() != 0) begin
            reportTimeout("the outstanding results");
        end
        expectedQ.delete(); // next test starts clean
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %0d %s finished with %0d errors", testCount, name,
                 errorCount - startErrors);
        startErrors = errorCount;
    endtask

    initial begin
        seed = 48;
        errorCount = 0;
        startErrors = 0;
        resultCount = 0;
        testCount = 0;
        cycle = 0;
        lastValidCycle = 0;
        firstWriteCycle = 0;
        checkSpacing = 1'b0;
        rst = 1'b0;
        botIn = '0;
        writeBotIn = 1'b0;
        slowDown = 1'b0;
        send = 1'b0;
        topValue = '0;

        topA = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
        botTable[0] = '1;
        botTable[1] = '0;
        botTable[2] = topA;
        botTable[3] = {topA[111:0], topA[127:112]}; // top rotated by 16
        botTable[4] = 128'h1 << 77;
        for (int i = 5; i < rowCount; i++) begin
            botTable[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        for (int i = 0; i < rowCount; i++) begin
            holdTable[i] = 0;
        end
        holdTable[holdRow] = 30;
        topB = {$random(seed), $random(seed), $random(seed), $random(seed)};

        repeat (2) @(posedge clock);
        #5;
        rst = 1'b1;
        checkBit("resultValid", 1'b0, resultValid);
        checkBit("almostFull", 1'b0, almostFull);

        // bots queued with no top loaded yet
        writeRow(0, topA);
        writeRow(1, topA);
        repeat (20) waitCycle();
        if (resultCount != 0) begin
            $display("a result appeared before any top was sent");
            errorCount++;
        end
        sendTop(topA);
        drainResults();
        finishTest("bots before top");

        for (int i = 2; i < 5; i++) begin
            writeRow(i, topA);
        end
        drainResults();
        finishTest("fixed patterns");

        lastValidCycle = 0;
        checkSpacing = 1'b1;
        writeRow(5, topA);
        firstWriteCycle = cycle;
        for (int i = 6; i < holdRow; i++) begin
            writeRow(i, topA);
        end
        drainResults();
        checkSpacing = 1'b0;
        finishTest("back to back bots");

        // the bot in flight finishes while the queue fills
        savedCount = resultCount;
        writeRow(holdRow, topA);
        waitCycle(); // pop happens before slowDown rises
        slowDown = 1'b1;
        for (int i = holdRow + 1; i <= holdRow + pipelinePkg::almostFullLevel; i++) begin
            checkBit("almostFull", 1'b0, almostFull);
            writeRow(i, topA);
        end
        checkBit("almostFull", 1'b1, almostFull);
        repeat (holdTable[holdRow]) waitCycle();
        if (resultCount - savedCount != 1) begin
            $display("ERR %0t resultValid pulses during slowDown expected 1 actual %0d",
                     $time, resultCount - savedCount);
            errorCount++;
        end
        slowDown = 1'b0;
        writeRow(holdRow, topA); // held until almostFull falls
        drainResults();
        finishTest("slowDown and almostFull");

        sendTop(topB);
        for (int i = 0; i < 5; i++) begin
            writeRow(i, topB);
        end
        drainResults();
        finishTest("new top");

        $display("%0d tests, %0d results, %0d errors", testCount, resultCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/topTransmitter.sv
`default_nettype none

// sends one top word as a framed bit stream, msb first
module topTransmitter (
    input  logic                 clock,
    input  logic                 send,
    input  pipelinePkg::botWord  topValue,
    output channelPkg::topSymbol channel,
    output logic                 done
);
    timeunit 1ns;
    timeprecision 100ps;

    pipelinePkg::botWord frameWord;

    initial begin
        channel = '0;
        done = 1'b0;
    end

    always @(posedge clock) begin
        if (send) begin
            frameWord = topValue; // latched so the caller may change topValue
            for (int i = channelPkg::topFrameLength - 1; i >= 0; i--) begin
                #5;
                channel.frame = 1'b1;
                channel.data = frameWord[i];
                @(posedge clock);
            end
            #5;
            channel = '0; // gap so the next frame is seen as new
            done = 1'b1;
            @(posedge clock);
            #5;
            done = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/permutationPipeline.sv
`default_nettype none

module permutationPipeline (
    input  logic                     clock,
    input  logic                     rst,
    input  channelPkg::topSymbol     topChannel,
    input  pipelinePkg::botWord      botIn,
    input  logic                     writeBotIn,
    output logic                     almostFull,
    input  logic                     slowDown,
    output logic                     resultValid,
    output pipelinePkg::pcoeffResult result
);

    pipelinePkg::botWord       topWord;
    pipelinePkg::botWord       botOut;
    pipelinePkg::rotationIndex rotation;
    pipelinePkg::stageTag      tag;
    logic                      topReady;
    logic                      fifoEmpty;
    logic                      pop;
    logic                      start;
    logic                      lastStep;

    topReceiver topReceiver0 (
        .clock      (clock),
        .rst        (rst),
        .topChannel (topChannel),
        .topWord    (topWord),
        .topReady   (topReady)
    );

    botFifo botFifo0 (
        .clock      (clock),
        .rst        (rst),
        .writeBotIn (writeBotIn),
        .botIn      (botIn),
        .pop        (pop),
        .botOut     (botOut),
        .fifoEmpty  (fifoEmpty),
        .almostFull (almostFull)
    );

    pipelineControl pipelineControl0 (
        .clock     (clock),
        .rst       (rst),
        .fifoEmpty (fifoEmpty),
        .topReady  (topReady),
        .slowDown  (slowDown),
        .lastStep  (lastStep),
        .pop       (pop),
        .start     (start)
    );

    // busy is internal to the timer here
    rotationTimer rotationTimer0 (
        .clock    (clock),
        .rst      (rst),
        .start    (start),
        .rotation (rotation),
        .tag      (tag),
        .busy     (),
        .lastStep (lastStep)
    );

    permutationStage permutationStage0 (
        .clock       (clock),
        .rst         (rst),
        .topWord     (topWord),
        .botOut      (botOut),
        .rotation    (rotation),
        .tag         (tag),
        .captureBot  (start),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

`default_nettype wire

//--- verilog/permutationStage.sv
`default_nettype none

module permutationStage (
    input  logic                      clock,
    input  logic                      rst,
    input  pipelinePkg::botWord       topWord,
    input  pipelinePkg::botWord       botOut,
    input  pipelinePkg::rotationIndex rotation,
    input  pipelinePkg::stageTag      tag,
    input  logic                      captureBot,
    output logic                      resultValid,
    output pipelinePkg::pcoeffResult  result
);

    pipelinePkg::botWord                  heldBot;
    pipelinePkg::botWord                  rotatedTop;
    pipelinePkg::botWord                  overlap;
    logic [2*pipelinePkg::botWidth-1:0]   doubledTop;
    logic                                 isSubset;
    logic [pipelinePkg::overlapWidth-1:0] overlapCount;
    logic                                 subsetHit;
    pipelinePkg::stageTag                 stageOneTag;
    pipelinePkg::pcoeffResult             accumulator;
    pipelinePkg::pcoeffResult             runTotal;

    function automatic logic [pipelinePkg::overlapWidth-1:0] countOnes(
        input pipelinePkg::botWord value
    );
        logic [pipelinePkg::overlapWidth-1:0] total;
        total = '0;
        for (int i = 0; i < pipelinePkg::botWidth; i++) begin
            total = total + value[i];
        end
        return total;
    endfunction

    // bot stays put for the whole run of eight rotations
    always_ff @(posedge clock) begin
        if (captureBot) begin
            heldBot <= botOut;
        end
    end

    // rotate left by 16 * rotation, upper half of the doubled word
    assign doubledTop = {topWord, topWord} << (pipelinePkg::rotationStep * rotation);
    assign rotatedTop = doubledTop[2*pipelinePkg::botWidth-1:pipelinePkg::botWidth];
    assign overlap    = heldBot & rotatedTop;
    assign isSubset   = (heldBot & ~rotatedTop) == '0;

    // stage one
    always_ff @(posedge clock) begin
        if (!rst) begin
            stageOneTag <= '0;
        end else begin
            stageOneTag <= tag;
        end
    end

    always_ff @(posedge clock) begin
        overlapCount <= countOnes(overlap);
        subsetHit    <= isSubset;
    end

    // running total including the step in stage one
    assign runTotal.sum   = accumulator.sum + 11'(overlapCount);
    assign runTotal.count = accumulator.count + 4'(subsetHit);

    // stage two
    always_ff @(posedge clock) begin
        if (stageOneTag.first) begin
            accumulator.sum   <= 11'(overlapCount);
            accumulator.count <= 4'(subsetHit);
        end else begin
            accumulator <= runTotal;
        end
        if (stageOneTag.last) begin
            result <= runTotal;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= stageOneTag.last; // one pulse per bot
        end
    end

endmodule

`default_nettype wire

//--- verilog/pipelineControl.sv
`default_nettype none

module pipelineControl (
    input  logic clock,
    input  logic rst,
    input  logic fifoEmpty,
    input  logic topReady,
    input  logic slowDown,
    input  logic lastStep,
    output logic pop,
    output logic start
);

    typedef enum logic {
        idle,
        run
    } controlState;

    controlState state;
    controlState nextState;
    logic        canIssue;

    // a bot waits, a top is loaded and nobody asks us to hold
    assign canIssue = !fifoEmpty && topReady && !slowDown;

    always_comb begin
        nextState = state;
        pop       = 1'b0;
        case (state)
            idle: begin
                if (canIssue) begin
                    pop       = 1'b1;
                    nextState = run;
                end
            end
            run: begin
                // next bot lines up behind the current run
                if (lastStep) begin
                    if (canIssue) begin
                        pop = 1'b1;
                    end else begin
                        nextState = idle;
                    end
                end
            end
            default: nextState = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            state <= idle;
            start <= 1'b0;
        end else begin
            state <= nextState;
            start <= pop; // bot data valid one cycle after pop
        end
    end

endmodule

`default_nettype wire

//--- verilog/rotationTimer.sv
`default_nettype none

module rotationTimer (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      start,
    output pipelinePkg::rotationIndex rotation,
    output pipelinePkg::stageTag      tag,
    output logic                      busy,
    output logic                      lastStep
);

    // last flag before it is registered into tag, one cycle ahead of tag.last
    assign lastStep = busy && rotation == pipelinePkg::lastRotation - 1'b1;

    always_ff @(posedge clock) begin
        if (!rst) begin
            busy     <= 1'b0;
            rotation <= '0;
            tag      <= '0;
        end else if (start) begin
            busy      <= 1'b1;
            rotation  <= '0;
            tag.first <= 1'b1;
            tag.last  <= 1'b0;
        end else if (busy && rotation == pipelinePkg::lastRotation) begin
            busy <= 1'b0; // stop at step 7, rotation holds
            tag  <= '0;
        end else if (busy) begin
            rotation  <= rotation + 1'b1;
            tag.first <= 1'b0;
            tag.last  <= lastStep;
        end
    end

endmodule

`default_nettype wire

//--- verilog/botFifo.sv
`default_nettype none

module botFifo (
    input  logic                clock,
    input  logic                rst,
    input  logic                writeBotIn,
    input  pipelinePkg::botWord botIn,
    input  logic                pop,
    output pipelinePkg::botWord botOut,
    output logic                fifoEmpty,
    output logic                almostFull
);

    pipelinePkg::botWord memory [pipelinePkg::fifoDepth];

    logic [pipelinePkg::fifoPointerWidth-1:0] writePtr;
    logic [pipelinePkg::fifoPointerWidth-1:0] readPtr;
    logic [pipelinePkg::fifoCountWidth-1:0]   occupancy;
    logic                                     doWrite;
    logic                                     doRead;

    // a write into a full queue is lost
    assign doWrite = writeBotIn && occupancy != pipelinePkg::fifoDepth;
    assign doRead  = pop && !fifoEmpty;

    assign fifoEmpty  = occupancy == 0;
    assign almostFull = occupancy >= pipelinePkg::almostFullLevel;

    always_ff @(posedge clock) begin
        if (!rst) begin
            writePtr  <= '0;
            readPtr   <= '0;
            occupancy <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1; // wraps at depth
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (doWrite) begin
            memory[writePtr] <= botIn;
        end
    end

    // one cycle read latency
    always_ff @(posedge clock) begin
        if (doRead) begin
            botOut <= memory[readPtr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/topReceiver.sv
`default_nettype none

module topReceiver (
    input  logic                 clock,
    input  logic                 rst,
    input  channelPkg::topSymbol topChannel,
    output pipelinePkg::botWord  topWord,
    output logic                 topReady
);

    logic [channelPkg::symbolCountWidth-1:0] symbolCount;
    logic [channelPkg::symbolCountWidth-1:0] nextCount;
    logic                                    framePrev;
    logic                                    frameStart;
    logic                                    counting;
    logic                                    completing;
    pipelinePkg::botWord                     shiftReg;

    // rising frame bit starts a new top
    assign frameStart = topChannel.frame && !framePrev;

    // extra framed symbols past the frame length are ignored
    assign counting = topChannel.frame &&
                      (frameStart || symbolCount < channelPkg::topFrameLength);

    assign nextCount = frameStart ? 1 : symbolCount + 1'b1;

    assign completing = counting && nextCount == channelPkg::topFrameLength;

    always_ff @(posedge clock) begin
        if (!rst) begin
            framePrev   <= 1'b0;
            symbolCount <= '0;
            topReady    <= 1'b0;
        end else begin
            framePrev <= topChannel.frame;
            if (counting) begin
                symbolCount <= nextCount;
            end
            if (completing) begin
                topReady <= 1'b1;
            end else if (frameStart) begin
                topReady <= 1'b0; // old top no longer valid
            end
        end
    end

    // msb arrives first, so shift in from the bottom
    always_ff @(posedge clock) begin
        if (counting) begin
            shiftReg <= {shiftReg[pipelinePkg::botWidth-2:0], topChannel.data};
        end
        if (completing) begin
            topWord <= {shiftReg[pipelinePkg::botWidth-2:0], topChannel.data};
        end
    end

endmodule

`default_nettype wire

//--- verilog/pipelinePkg.sv
`default_nettype none

// words, results and sizes of the permutation pipeline
package pipelinePkg;

    localparam int botWidth = 128;

    // same width serves top and bot
    typedef logic [botWidth-1:0] botWord;

    // eight rotations of the top, 16 bits apart
    localparam int rotationCount = 8;
    localparam int rotationStep = 16;

    typedef logic [2:0] rotationIndex;

    localparam rotationIndex lastRotation = rotationIndex'(rotationCount - 1);

    // popcount of one overlap, up to 128
    localparam int overlapWidth = 8;

    // sum up to 8 * 128, count up to 8
    typedef struct packed {
        logic [10:0] sum;
        logic [3:0]  count;
    } pcoeffResult;

    // flags riding with each rotation step
    typedef struct packed {
        logic first;
        logic last;
    } stageTag;

    // input queue
    localparam int fifoDepth = 16;
    localparam int almostFullLevel = 12;
    localparam int fifoPointerWidth = $clog2(fifoDepth);
    localparam int fifoCountWidth = $clog2(fifoDepth + 1);

endpackage

`default_nettype wire

//--- verilog/channelPkg.sv
`default_nettype none

// serial top channel, one symbol per clock
package channelPkg;

    // frame marks a top bit on the wire, data is that bit (msb first)
    typedef struct packed {
        logic frame;
        logic data;
    } topSymbol;

    // symbols in one top frame
    localparam int topFrameLength = 128;

    // receiver symbol counter, holds up to topFrameLength
    localparam int symbolCountWidth = 8;

endpackage

`default_nettype wire
